/* src/calc_params.svh */
`ifndef CALC_PARAMS_SVH
`define CALC_PARAMS_SVH

// datapath sizes
`define CALC_PORTS      4
`define CALC_DATA_W     32
`define CALC_CMD_W      4
`define CALC_RESP_W     2
`define CALC_SHIFT_W    5           // only low bits of operand 2 count for shifts

// command codes, anything else nonzero is rejected
`define CALC_CMD_NOP    4'd0
`define CALC_CMD_ADD    4'd1
`define CALC_CMD_SUB    4'd2
`define CALC_CMD_SHL    4'd5
`define CALC_CMD_SHR    4'd6

// response codes
`define CALC_RESP_NONE   2'd0
`define CALC_RESP_OK     2'd1
`define CALC_RESP_ERR    2'd2       // add overflow or sub underflow
`define CALC_RESP_BADCMD 2'd3

`endif

/* src/calc_pkg.sv */
`default_nettype none

`include "calc_params.svh"

package calc_pkg;

	typedef logic [`CALC_DATA_W-1:0] calc_data_t;      // operand or result
	typedef logic [`CALC_CMD_W-1:0]  calc_cmd_t;       // command code
	typedef logic [`CALC_RESP_W-1:0] calc_resp_t;      // response code

	// port index, port 1 of the bus is index 0
	typedef logic [$clog2(`CALC_PORTS)-1:0] calc_port_t;

	// two-beat request collection per port
	typedef enum logic [1:0] {
		CAP_IDLE    = 2'd0,                        // waiting for beat 1
		CAP_OP2     = 2'd1,                        // beat 1 seen, next cycle is operand 2
		CAP_PENDING = 2'd2                         // full request held until granted
	} calc_cap_state_e;

endpackage

`default_nettype wire

/* src/calc_port_capture.sv */
`timescale 1ns/1ps
`default_nettype none

`include "calc_params.svh"

module calc_port_capture import calc_pkg::*; (
	input  wire logic       c_clk,
	input  wire logic       rst_n,
	input  wire calc_cmd_t  req_cmd,
	input  wire calc_data_t req_data,
	input  wire logic       grant_clear,
	output logic            pend_valid,
	output calc_cmd_t       pend_cmd,
	output calc_data_t      pend_op1,
	output calc_data_t      pend_op2
);

	calc_cap_state_e state;

	always_ff @(posedge c_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= CAP_IDLE;
		end else begin
			case (state)
				CAP_IDLE:    if (req_cmd != `CALC_CMD_NOP) state <= CAP_OP2;  // no-op stays idle
				CAP_OP2:     state <= CAP_PENDING;
				CAP_PENDING: if (grant_clear) state <= CAP_IDLE;
				default:     state <= CAP_IDLE;
			endcase
		end
	end

	// request payload, only written while the FSM expects that beat
	always_ff @(posedge c_clk) begin
		if (state == CAP_IDLE && req_cmd != `CALC_CMD_NOP) begin
			pend_cmd <= req_cmd;                   // bad codes are kept and answered later
			pend_op1 <= req_data;
		end
		if (state == CAP_OP2) begin
			pend_op2 <= req_data;
		end
	end

	// high from the edge that takes operand 2 until the edge after the grant
	assign pend_valid = (state == CAP_PENDING);

endmodule

`default_nettype wire

/* src/calc_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "calc_params.svh"

module calc_arbiter import calc_pkg::*; (
	input  wire logic                      c_clk,
	input  wire logic                      rst_n,
	input  wire logic [`CALC_PORTS-1:0]    pend_valid,
	input  wire calc_cmd_t [`CALC_PORTS-1:0]  pend_cmd,
	input  wire calc_data_t [`CALC_PORTS-1:0] pend_op1,
	input  wire calc_data_t [`CALC_PORTS-1:0] pend_op2,
	output logic [`CALC_PORTS-1:0]         grant_clear,
	output logic                           iss_valid,
	output calc_port_t                     iss_port,
	output calc_cmd_t                      iss_cmd,
	output calc_data_t                     iss_op1,
	output calc_data_t                     iss_op2
);

	logic                   any;
	calc_port_t             sel;

	// the lowest pending index wins
	// a granted capture drops pend_valid at the next edge and cannot win twice in a row
	always_comb begin
		any = 1'b0;
		sel = '0;
		grant_clear = '0;
		for (int p = `CALC_PORTS-1; p >= 0; p--) begin
			if (pend_valid[p]) begin
				any = 1'b1;
				sel = calc_port_t'(p);
			end
		end
		grant_clear[sel] = any;
	end

	always_ff @(posedge c_clk or negedge rst_n) begin
		if (!rst_n) begin
			iss_valid  <= 1'b0;
		end else begin
			iss_valid  <= any;
		end
	end

	always_ff @(posedge c_clk) begin
		if (any) begin
			iss_port <= sel;
			iss_cmd  <= pend_cmd[sel];
			iss_op1  <= pend_op1[sel];
			iss_op2  <= pend_op2[sel];
		end
	end

endmodule

`default_nettype wire

/* src/calc_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "calc_params.svh"

module calc_alu import calc_pkg::*; (
	input  wire logic       c_clk,
	input  wire logic       rst_n,
	input  wire logic       iss_valid,
	input  wire calc_port_t iss_port,
	input  wire calc_cmd_t  iss_cmd,
	input  wire calc_data_t iss_op1,
	input  wire calc_data_t iss_op2,
	output logic            res_valid,
	output calc_port_t      res_port,
	output calc_resp_t      res_resp,
	output calc_data_t      res_data
);

	logic [`CALC_DATA_W:0]    sum;                // msb is the carry
	logic [`CALC_DATA_W:0]    diff;               // msb is the borrow
	logic [`CALC_SHIFT_W-1:0] shamt;
	calc_resp_t               resp_n;
	calc_data_t               data_n;

	assign sum   = {1'b0, iss_op1} + {1'b0, iss_op2};
	assign diff  = {1'b0, iss_op1} - {1'b0, iss_op2};
	assign shamt = iss_op2[`CALC_SHIFT_W-1:0];    // 33 shifts by 1

	always_comb begin
		resp_n = `CALC_RESP_OK;
		data_n = '0;
		case (iss_cmd)
			`CALC_CMD_ADD: begin
				if (sum[`CALC_DATA_W]) resp_n = `CALC_RESP_ERR;
				else data_n = sum[`CALC_DATA_W-1:0];
			end
			`CALC_CMD_SUB: begin
				if (diff[`CALC_DATA_W]) resp_n = `CALC_RESP_ERR;   // op2 larger than op1
				else data_n = diff[`CALC_DATA_W-1:0];
			end
			`CALC_CMD_SHL: data_n = iss_op1 << shamt;
			`CALC_CMD_SHR: data_n = iss_op1 >> shamt;
			default:       resp_n = `CALC_RESP_BADCMD;
		endcase
	end

	always_ff @(posedge c_clk or negedge rst_n) begin
		if (!rst_n) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= iss_valid;
		end
	end

	always_ff @(posedge c_clk) begin
		if (iss_valid) begin
			res_port <= iss_port;
			res_resp <= resp_n;
			res_data <= data_n;                    // zero on any error code
		end
	end

endmodule

`default_nettype wire

/* src/calc_resp_route.sv */
`timescale 1ns/1ps
`default_nettype none

`include "calc_params.svh"

module calc_resp_route import calc_pkg::*; (
	input  wire logic                  c_clk,
	input  wire logic                  rst_n,
	input  wire logic                  res_valid,
	input  wire calc_port_t            res_port,
	input  wire calc_resp_t            res_resp,
	input  wire calc_data_t            res_data,
	output calc_resp_t [`CALC_PORTS-1:0] out_resp,
	output calc_data_t [`CALC_PORTS-1:0] out_data
);

	// every port is rewritten each cycle, so a response never lasts past one cycle
	always_ff @(posedge c_clk or negedge rst_n) begin
		if (!rst_n) begin
			out_resp <= '0;
			out_data <= '0;
		end else begin
			for (int p = 0; p < `CALC_PORTS; p++) begin
				if (res_valid && res_port == calc_port_t'(p)) begin
					out_resp[p] <= res_resp;
					out_data[p] <= res_data;
				end else begin
					out_resp[p] <= `CALC_RESP_NONE;  // idle ports read as zero
					out_data[p] <= '0;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* src/calc_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "calc_params.svh"

module calc_top import calc_pkg::*; (
	input  wire logic                      c_clk,
	input  wire logic                      rst_n,
	input  wire calc_cmd_t [`CALC_PORTS-1:0]  req_cmd,
	input  wire calc_data_t [`CALC_PORTS-1:0] req_data,
	output calc_resp_t [`CALC_PORTS-1:0]   out_resp,
	output calc_data_t [`CALC_PORTS-1:0]   out_data
);

	logic [`CALC_PORTS-1:0]         pend_valid;
	calc_cmd_t [`CALC_PORTS-1:0]    pend_cmd;
	calc_data_t [`CALC_PORTS-1:0]   pend_op1;
	calc_data_t [`CALC_PORTS-1:0]   pend_op2;
	logic [`CALC_PORTS-1:0]         grant_clear;

	logic       iss_valid;
	calc_port_t iss_port;
	calc_cmd_t  iss_cmd;
	calc_data_t iss_op1;
	calc_data_t iss_op2;

	logic       res_valid;
	calc_port_t res_port;
	calc_resp_t res_resp;
	calc_data_t res_data;

	// one request collector per port
	for (genvar g = 0; g < `CALC_PORTS; g++) begin : g_cap
		calc_port_capture cap_i (
			.c_clk       (c_clk),
			.rst_n       (rst_n),
			.req_cmd     (req_cmd[g]),
			.req_data    (req_data[g]),
			.grant_clear (grant_clear[g]),
			.pend_valid  (pend_valid[g]),
			.pend_cmd    (pend_cmd[g]),
			.pend_op1    (pend_op1[g]),
			.pend_op2    (pend_op2[g])
		);
	end

	calc_arbiter arb_i (
		.c_clk       (c_clk),
		.rst_n       (rst_n),
		.pend_valid  (pend_valid),
		.pend_cmd    (pend_cmd),
		.pend_op1    (pend_op1),
		.pend_op2    (pend_op2),
		.grant_clear (grant_clear),
		.iss_valid   (iss_valid),
		.iss_port    (iss_port),
		.iss_cmd     (iss_cmd),
		.iss_op1     (iss_op1),
		.iss_op2     (iss_op2)
	);

	calc_alu alu_i (
		.c_clk     (c_clk),
		.rst_n     (rst_n),
		.iss_valid (iss_valid),
		.iss_port  (iss_port),
		.iss_cmd   (iss_cmd),
		.iss_op1   (iss_op1),
		.iss_op2   (iss_op2),
		.res_valid (res_valid),
		.res_port  (res_port),
		.res_resp  (res_resp),
		.res_data  (res_data)
	);

	calc_resp_route route_i (
		.c_clk     (c_clk),
		.rst_n     (rst_n),
		.res_valid (res_valid),
		.res_port  (res_port),
		.res_resp  (res_resp),
		.res_data  (res_data),
		.out_resp  (out_resp),
		.out_data  (out_data)
	);

endmodule

`default_nettype wire

/* testbench/calc_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "calc_params.svh"

module calc_monitor import calc_pkg::*; (
	input  wire logic                         c_clk,
	input  wire logic                         rst_n,
	input  wire calc_resp_t [`CALC_PORTS-1:0] out_resp,
	input  wire calc_data_t [`CALC_PORTS-1:0] out_data,
	input  wire logic                         exp_push,
	input  wire calc_port_t                   exp_port,
	input  wire calc_resp_t                   exp_resp,
	input  wire calc_data_t                   exp_data,
	input  wire logic                         exp_conc,
	input  wire logic                         test_done,
	input  wire logic [15:0]                  test_id,
	output int                                outstanding,
	output int                                err_count,
	output int                                test_count,
	output int                                fail_count
);

	logic [36:0] exp_q[$];                         // {conc, port, resp, data}
	int cycle = 0;
	int conc_base = 0;                             // cycle of port 1 answer in a group
	int test_errs = 0;
	int errs = 0;
	int tests = 0;
	int fails = 0;
	int pending = 0;

	assign outstanding = pending;
	assign err_count = errs;
	assign test_count = tests;
	assign fail_count = fails;

	function automatic int find_entry(input int p);
		logic [36:0] e;
		for (int k = 0; k < exp_q.size(); k++) begin
			e = exp_q[k];
			if (int'(e[35:34]) == p) begin
				return k;
			end
		end
		return -1;
	endfunction

	task automatic report_err(input string msg);
		$display("ERR %0t: %s", $time, msg);
		errs++;
		test_errs++;
	endtask

	// outputs settle after the rising edge, so look on the falling one
	always @(negedge c_clk) begin
		int idx;
		logic [36:0] e;
		cycle++;
		for (int p = 0; p < `CALC_PORTS; p++) begin
			if (out_resp[p] == `CALC_RESP_NONE) begin
				if (out_data[p] != '0) begin
					report_err($sformatf("port %0d data %h without response", p + 1, out_data[p]));
				end
			end else if (!rst_n) begin
				report_err($sformatf("port %0d response %0d in reset", p + 1, out_resp[p]));
			end else begin
				idx = find_entry(p);
				if (idx < 0) begin
					$display("unexpected response %0d on port %0d at %0t", out_resp[p], p + 1, $time);
					errs++;
					test_errs++;
				end else begin
					e = exp_q[idx];
					exp_q.delete(idx);
					if (out_resp[p] != e[33:32] || out_data[p] != e[31:0]) begin
						report_err($sformatf("port %0d got %0d/%h, expected %0d/%h", p + 1,
							out_resp[p], out_data[p], e[33:32], e[31:0]));
					end
					if (e[36]) begin
						if (p == 0) begin
							conc_base = cycle;
						end else if (cycle != conc_base + p) begin
							$display("port %0d answered out of order in a concurrent group", p + 1);
							errs++;
							test_errs++;
						end
					end
				end
			end
		end
		if (exp_push) begin
			exp_q.push_back({exp_conc, exp_port, exp_resp, exp_data});
		end
		if (test_done) begin
			while (exp_q.size() > 0) begin
				e = exp_q.pop_front();
				$display("missing response on port %0d in test %0d", int'(e[35:34]) + 1, test_id);
				errs++;
				test_errs++;
			end
			tests++;
			if (test_errs != 0) begin
				fails++;
			end
			$display("test %0d %s, %0d errors", test_id, (test_errs == 0) ? "ok" : "bad", test_errs);
			test_errs = 0;
		end
		pending = exp_q.size();
	end

endmodule

`default_nettype wire

/* testbench/calc_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "calc_params.svh"

module calc_checker import calc_pkg::*; (
	input wire logic                         c_clk,
	input wire logic                         rst_n,
	input wire calc_resp_t [`CALC_PORTS-1:0] out_resp,
	input wire calc_data_t [`CALC_PORTS-1:0] out_data
);

	logic [`CALC_PORTS-1:0] busy;                 // ports answering this cycle

	for (genvar g = 0; g < `CALC_PORTS; g++) begin : g_port
		assign busy[g] = (out_resp[g] != `CALC_RESP_NONE);

		a_pulse: assert property (@(posedge c_clk) disable iff (!rst_n) busy[g] |=> !busy[g])
			else $error("port %0d response held for two cycles", g + 1);

		a_idle: assert property (@(posedge c_clk) disable iff (!rst_n)
			!busy[g] |-> out_data[g] == '0)
			else $error("port %0d data nonzero while idle", g + 1);
	end

	a_one: assert property (@(posedge c_clk) disable iff (!rst_n) $onehot0(busy))
		else $error("more than one port answers in the same cycle");

endmodule

bind calc_top calc_checker chk_i (
	.c_clk    (c_clk),
	.rst_n    (rst_n),
	.out_resp (out_resp),
	.out_data (out_data)
);

`default_nettype wire

/* testbench/calc_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "calc_params.svh"

module calc_tb import calc_pkg::*; ();

	logic c_clk = 1'b0;
	logic rst_n;
	calc_cmd_t [`CALC_PORTS-1:0]  req_cmd;
	calc_data_t [`CALC_PORTS-1:0] req_data;
	calc_resp_t [`CALC_PORTS-1:0] out_resp;
	calc_data_t [`CALC_PORTS-1:0] out_data;

	// expectations handed to the monitor with NBAs on the falling edge
	logic        exp_push;
	logic        exp_conc;
	calc_port_t  exp_port;
	calc_resp_t  exp_resp;
	calc_data_t  exp_data;
	logic        test_done;
	logic [15:0] test_id;
	int          outstanding;
	int          err_count;
	int          test_count;
	int          fail_count;

	// golden vectors with one entry per file line
	int         v_id[$];
	int         v_conc[$];
	int         v_port[$];                     // 1 to 4
	int         v_resp[$];
	calc_cmd_t  v_cmd[$];
	calc_data_t v_op1[$];
	calc_data_t v_op2[$];
	calc_data_t v_data[$];
	int         n_vec = 0;
	logic [31:0] lfsr;

	always #20 c_clk = ~c_clk;

	calc_top dut_i (
		.c_clk    (c_clk),
		.rst_n    (rst_n),
		.req_cmd  (req_cmd),
		.req_data (req_data),
		.out_resp (out_resp),
		.out_data (out_data)
	);

	calc_monitor mon_i (
		.c_clk       (c_clk),
		.rst_n       (rst_n),
		.out_resp    (out_resp),
		.out_data    (out_data),
		.exp_push    (exp_push),
		.exp_port    (exp_port),
		.exp_resp    (exp_resp),
		.exp_data    (exp_data),
		.exp_conc    (exp_conc),
		.test_done   (test_done),
		.test_id     (test_id),
		.outstanding (outstanding),
		.err_count   (err_count),
		.test_count  (test_count),
		.fail_count  (fail_count)
	);

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic idle_gap();
		int gap;
		gap = 0;
		repeat (2) begin
			lfsr = lfsr_step(lfsr);                // one step per gap bit
			gap = gap * 2 + int'(lfsr[0]);
		end
		repeat (gap) @(negedge c_clk);
	endtask

	task automatic load_vectors(output bit ok);
		int fd;
		int n;
		int cnt;
		string line;
		int f_id;
		int f_conc;
		int f_port;
		int f_resp;
		calc_cmd_t f_cmd;
		calc_data_t f_op1;
		calc_data_t f_op2;
		calc_data_t f_data;
		ok = 1'b0;
		fd = $fopen("testbench/calc_golden.txt", "r");
		if (fd == 0) begin
			$display("cannot open testbench/calc_golden.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				cnt = $fgets(line, fd);
				if (cnt > 1 && line[0] != "#") begin
					n = $sscanf(line, "%d %d %d %h %h %h %d %h", f_id, f_conc, f_port, f_cmd,
						f_op1, f_op2, f_resp, f_data);
					if (n == 8) begin
						v_id.push_back(f_id);
						v_conc.push_back(f_conc);
						v_port.push_back(f_port);
						v_cmd.push_back(f_cmd);
						v_op1.push_back(f_op1);
						v_op2.push_back(f_op2);
						v_resp.push_back(f_resp);
						v_data.push_back(f_data);
					end
				end
			end
			$fclose(fd);
			if (v_id.size() == 0) begin
				$display("golden file holds no vectors");
			end else begin
				ok = 1'b1;
			end
		end
	endtask

	task automatic push_expect(input int i);
		@(negedge c_clk);
		exp_push <= 1'b1;
		exp_port <= calc_port_t'(v_port[i] - 1);
		exp_resp <= calc_resp_t'(v_resp[i]);
		exp_data <= v_data[i];
		exp_conc <= (v_conc[i] != 0);
		test_id  <= 16'(v_id[i]);
		@(negedge c_clk);
		exp_push <= 1'b0;
	endtask

	// beat 1 on every port of the group together, then operand 2
	task automatic send_group(input int first, input int count);
		int p;
		@(negedge c_clk);
		for (int k = first; k < first + count; k++) begin
			p = v_port[k] - 1;
			req_cmd[p] = v_cmd[k];
			req_data[p] = v_op1[k];
		end
		@(negedge c_clk);
		for (int k = first; k < first + count; k++) begin
			p = v_port[k] - 1;
			req_cmd[p] = `CALC_CMD_NOP;
			req_data[p] = v_op2[k];
		end
		@(negedge c_clk);
		req_data = '0;
	endtask

	// a group holding a no-op always sits out the full window
	task automatic wait_group(input int first, input int count);
		int cycles;
		bit noop;
		cycles = 0;
		noop = 1'b0;
		for (int k = first; k < first + count; k++) begin
			if (v_resp[k] == 0) begin
				noop = 1'b1;
			end
		end
		do begin
			@(posedge c_clk);
			cycles++;
		end while (cycles < 10 && (noop || outstanding != 0));
	endtask

	task automatic end_test(input int id);
		@(negedge c_clk);
		test_done <= 1'b1;
		test_id   <= 16'(id);
		@(negedge c_clk);
		test_done <= 1'b0;
	endtask

	task automatic run_vectors();
		int i;
		int n;
		i = 0;
		while (i < n_vec) begin
			n = 1;
			if (v_conc[i] != 0) begin
				while (i + n < n_vec && v_conc[i + n] != 0 && v_id[i + n] == v_id[i]) begin
					n++;
				end
			end
			for (int k = i; k < i + n; k++) begin
				if (v_resp[k] != 0) begin
					push_expect(k);
				end
			end
			send_group(i, n);
			wait_group(i, n);
			i += n;
			if (i >= n_vec || v_id[i] != v_id[i - 1]) begin
				end_test(v_id[i - 1]);
			end
			idle_gap();
		end
	endtask

	initial begin
		bit loaded;
		rst_n = 1'b0;
		req_cmd = '0;
		req_data = '0;
		exp_push <= 1'b0;
		exp_conc <= 1'b0;
		exp_port <= '0;
		exp_resp <= '0;
		exp_data <= '0;
		test_done <= 1'b0;
		test_id <= '0;
		lfsr = 32'hb65a_5bb4;
		load_vectors(loaded);
		if (!loaded) begin
			$display("Test failed");
			$finish;
		end else begin
			n_vec = v_id.size();

			repeat (5) @(posedge c_clk);
			@(negedge c_clk);
			rst_n = 1'b1;

			run_vectors();

			@(negedge c_clk);
			@(posedge c_clk);
			$display("tests %0d, failing tests %0d, errors %0d", test_count, fail_count,
				err_count);
			if (err_count == 0 && fail_count == 0 && test_count > 0) begin
				$display("Test passed");
			end else begin
				$display("Test failed");
			end
			$finish;
		end
	end

	// 15 cycles of 40 ns per golden line plus 1 us of slack
	initial begin
		wait (n_vec > 0);
		#(n_vec * 15 * 40 + 1000);
		$display("watchdog expired before the tests finished");
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/calc_golden.txt */
# test group port cmd op1 op2 resp data
# group 1 is concurrent; cmd op1 op2 data in hex; resp 0 means no response
1 0 1 0 00000005 00000003 0 00000000
1 0 2 0 00000005 00000003 0 00000000
1 0 3 0 ffffffff 00000001 0 00000000
1 0 4 0 00000010 00000020 0 00000000
2 0 1 1 ffffffff 00000001 2 00000000
2 0 2 2 00000003 00000005 2 00000000
2 0 3 3 00001234 00000001 3 00000000
2 0 4 f 00000010 00000020 3 00000000
3 0 1 1 fffffffe 00000001 1 ffffffff
3 0 2 1 7fffffff 80000001 2 00000000
3 0 3 2 12345678 12345678 1 00000000
3 0 4 2 00000000 00000001 2 00000000
3 0 1 5 00000001 00000000 1 00000001
3 0 2 5 00000001 0000001f 1 80000000
3 0 3 6 80000000 0000001f 1 00000001
3 0 4 6 f0000000 00000021 1 78000000
4 0 2 1 00010000 00020000 1 00030000
4 0 2 2 00030000 00010000 1 00020000
4 0 4 5 00000003 00000024 1 00000030
5 1 1 1 00000064 000000c8 1 0000012c
5 1 2 2 000000c8 00000064 1 00000064
5 1 3 5 0000000f 00000008 1 00000f00
5 1 4 6 0000ff00 00000004 1 00000ff0

/* tb.f */
+incdir+src
src/calc_pkg.sv
src/calc_port_capture.sv
src/calc_arbiter.sv
src/calc_alu.sv
src/calc_resp_route.sv
src/calc_top.sv
testbench/calc_monitor.sv
testbench/calc_checker.sv
testbench/calc_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module calc_tb -o calc_sim

out=$(./obj_dir/calc_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
	exit 0
fi
exit 1
